// File: bench/decodePipeTb.sv
// Self-checking testbench for decodePipe; the first failed check stops the run
// Random part is reproducible from the fixed LCG seed
`timescale 1ns/1ns

module decodePipeTb
	import mipsPkg::*;
();

	localparam int resetCycles  = 8;
	localparam int directedMax  = 60;	// Directed list plus drain, with room
	localparam int randomCycles = 600;
	localparam int maxCycles    = (resetCycles + directedMax + randomCycles) * 3 / 2;

	// Expected view of one slot as it moves down the pipe
	typedef struct packed {
		logic        fl;
		exCtrl_t     ex;
		memCtrl_t    mem;
		wbCtrl_t     wb;
		logic [4:0]  dest;
		aluFunc_t    alu;
		logic        isBeq;
		logic        isBne;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [31:0] pc4;
	} slotExp_t;

	logic        CLK = 1'b0;
	logic        rstN;
	logic [31:0] idInstr;
	logic [31:0] idPc;
	logic        flush;
	logic        wbWrite;
	logic [4:0]  wbAddr;
	logic [31:0] wbData;
	logic [31:0] rsData;
	logic [31:0] rtData;
	exCtrl_t     exCtrl;
	aluFunc_t    aluFunc;
	memCtrl_t    memCtrl;
	wbCtrl_t     wbCtrl;
	logic [4:0]  exDest;
	logic [4:0]  memDest;
	logic [4:0]  wbDest;
	logic        redirect;
	logic [31:0] redirectPc;

	slotExp_t    s1;	// Slot now in EX
	slotExp_t    s2;	// MEM
	slotExp_t    s3;	// WB
	logic [31:0] shadow [32];	// Register contents as written so far
	logic [31:0] expRs;
	logic [31:0] expRt;
	logic [31:0] expPc;
	logic [31:0] idPc4;
	logic        expRedirect;
	logic        brTaken;
	logic        jumpImm;
	logic        jumpReg;
	logic [31:0] pc = 32'h0040_0000;
	logic [31:0] lcgState = 32'hf543_dbf2;
	int          cycleCount = 0;

	logic [5:0] fnList [10] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnMfhi, fnMflo, fnMult,
		fnDiv, 6'h3f};	// Last one unknown

	decodePipe dut0 (.*);

	always #10 CLK = ~CLK;	// 20 ns period

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic aluFunc_t aluRef(input logic [2:0] aluOp, input logic [1:0] hiLo,
		input logic [5:0] fn);
		aluFunc_t byFunct;
		aluFunc_t f;
		case (fn)
			fnSub:   byFunct = aluSub;
			fnAnd:   byFunct = aluAnd;
			fnOr:    byFunct = aluOr;
			fnSlt:   byFunct = aluSlt;
			default: byFunct = aluAdd;	// add and unknown funct
		endcase
		case (aluOp)
			3'b001:  f = (hiLo == 2'b10) ? aluMfhi : ((hiLo == 2'b01) ? aluMflo : byFunct);
			3'b010:  f = aluAnd;
			3'b011:  f = aluOr;
			3'b100:  f = aluSub;
			3'b101:  f = aluSub;
			3'b110:  f = aluSlt;
			3'b111:  f = aluPass;
			default: f = aluAdd;
		endcase
		return f;
	endfunction

	// Decode table, one row per instruction
	function automatic slotExp_t refSlot(input logic [31:0] instr, input logic fl,
		input logic [31:0] rsVal, input logic [31:0] rtVal, input logic [31:0] pcIn);
		slotExp_t   s;
		logic [12:0] row;	// aluOp aluSrc hiLo | memRead memWrite | memToReg regWrite | regDst
		logic [5:0]  op;
		logic [5:0]  fn;
		op = instr[31:26];
		fn = instr[5:0];
		case (op)
			opJ:    row = 13'b111_0_00_00_00_0_01;
			opJal:  row = 13'b111_0_00_00_10_1_10;
			opAddi: row = 13'b000_1_00_00_00_1_00;
			opAndi: row = 13'b010_1_00_00_00_1_00;
			opOri:  row = 13'b011_1_00_00_00_1_00;
			opSlti: row = 13'b110_1_00_00_00_1_00;
			opBeq:  row = 13'b100_0_00_00_00_0_01;
			opBne:  row = 13'b101_0_00_00_00_0_01;
			opLw:   row = 13'b000_1_00_10_01_1_00;
			opSw:   row = 13'b000_1_00_01_00_0_01;
			opR:
			begin
				case (fn)
					fnMult:  row = 13'b001_0_00_00_00_0_01;
					fnDiv:   row = 13'b001_0_00_00_00_0_01;
					fnMfhi:  row = 13'b001_0_10_00_00_1_01;
					fnMflo:  row = 13'b001_0_01_00_00_1_01;
					default: row = 13'b001_0_00_00_00_1_01;	// jr only adds the jump
				endcase
			end
			default: row = 13'b001_0_00_00_00_1_01;	// Unlisted opcode, plain R-type
		endcase
		s       = '0;	// Flushed slot is cleared whole in ID/EX
		s.fl    = fl;
		s.rsVal = rsVal;
		s.rtVal = rtVal;
		s.imm   = {{16{instr[15]}}, instr[15:0]};
		s.pc4   = pcIn + 32'd4;
		if (!fl)
		begin
			s.ex    = row[12:7];
			s.mem   = row[6:5];
			s.wb    = row[4:2];
			s.dest  = (row[1:0] == 2'b00) ? instr[20:16] :
				((row[1:0] == 2'b01) ? instr[15:11] : 5'd31);
			s.isBeq = (op == opBeq);
			s.isBne = (op == opBne);
		end
		s.alu = aluRef(s.ex.aluOp, s.ex.hiLo, s.fl ? 6'd0 : fn);
		return s;
	endfunction

	function automatic logic [5:0] pickOpcode(input logic [3:0] r);
		case (r)
			4'd4:    return opJ;
			4'd5:    return opJal;
			4'd6:    return opBeq;
			4'd7:    return opBne;
			4'd8:    return opAddi;
			4'd9:    return opSlti;
			4'd10:   return opAndi;
			4'd11:   return opOri;
			4'd12:   return opLw;
			4'd13:   return opSw;
			4'd14:   return 6'b111111;	// Not in the table
			4'd15:   return opBeq;
			default: return opR;
		endcase
	endfunction

	function automatic logic [5:0] pickFunct(input logic [5:0] r);
		case (r[3:0])
			4'd0:    return fnAdd;
			4'd1:    return fnSub;
			4'd2:    return fnAnd;
			4'd3:    return fnOr;
			4'd4:    return fnSlt;
			4'd5:    return fnJr;
			4'd6:    return fnMfhi;
			4'd7:    return fnMflo;
			4'd8:    return fnMult;
			4'd9:    return fnDiv;
			default: return r;	// Any code, mostly unknown
		endcase
	endfunction

	task automatic reportMismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		$display("mismatch at %0t ns: %s got %0h expected %0h", $time, sig, got, exp);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportFailure(input string what);
		$display("error at %0t ns: %s", $time, what);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic issue(input logic [31:0] instr, input logic fl, input logic we,
		input logic [4:0] wa, input logic [31:0] wd);
		@(posedge CLK);
		idInstr <= instr;
		idPc    <= pc;
		flush   <= fl;
		wbWrite <= we;
		wbAddr  <= wa;
		wbData  <= wd;
		pc = pc + 32'd4;
	endtask

	task automatic issuePlain(input logic [31:0] instr);
		issue(instr, 1'b0, 1'b0, 5'd0, 32'd0);
	endtask

	// Read port model, bypass for a landing write
	always_comb
	begin
		expRs = (wbWrite && wbAddr != 5'd0 && wbAddr == idInstr[25:21]) ? wbData
			: shadow[idInstr[25:21]];
		expRt = (wbWrite && wbAddr != 5'd0 && wbAddr == idInstr[20:16]) ? wbData
			: shadow[idInstr[20:16]];
	end

	// Next-PC model, branch in EX first
	always_comb
	begin
		brTaken = (s1.isBeq && s1.rsVal == s1.rtVal) || (s1.isBne && s1.rsVal != s1.rtVal);
		jumpImm = !flush && (idInstr[31:26] == opJ || idInstr[31:26] == opJal);
		jumpReg = !flush && idInstr[31:26] == opR && idInstr[5:0] == fnJr;
		idPc4   = idPc + 32'd4;
		expRedirect = brTaken || jumpImm || jumpReg;
		if (brTaken)
			expPc = s1.pc4 + {s1.imm[29:0], 2'b00};
		else if (jumpImm)
			expPc = {idPc4[31:28], idInstr[25:0], 2'b00};	// Region from PC+4
		else
			expPc = expRs;
	end

	always @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			s1 <= '0;
			s2 <= '0;
			s3 <= '0;
			for (int i = 0; i < 32; i++)
				shadow[i] <= '0;
		end
		else
		begin
			s1 <= refSlot(idInstr, flush, expRs, expRt, idPc);
			s2 <= s1;
			s3 <= s2;
			if (wbWrite && wbAddr != 5'd0)
				shadow[wbAddr] <= wbData;
		end
	end

	exCtrlCheck: assert property (@(posedge CLK) disable iff (!rstN) exCtrl == s1.ex)
		else reportMismatch("exCtrl", $sampled(exCtrl), $sampled(s1.ex));
	exDestCheck: assert property (@(posedge CLK) disable iff (!rstN) exDest == s1.dest)
		else reportMismatch("exDest", $sampled(exDest), $sampled(s1.dest));
	aluFuncCheck: assert property (@(posedge CLK) disable iff (!rstN) aluFunc == s1.alu)
		else reportMismatch("aluFunc", $sampled(aluFunc), $sampled(s1.alu));
	memCtrlCheck: assert property (@(posedge CLK) disable iff (!rstN) memCtrl == s2.mem)
		else reportMismatch("memCtrl", $sampled(memCtrl), $sampled(s2.mem));
	memDestCheck: assert property (@(posedge CLK) disable iff (!rstN) memDest == s2.dest)
		else reportMismatch("memDest", $sampled(memDest), $sampled(s2.dest));
	wbCtrlCheck: assert property (@(posedge CLK) disable iff (!rstN) wbCtrl == s3.wb)
		else reportMismatch("wbCtrl", $sampled(wbCtrl), $sampled(s3.wb));
	wbDestCheck: assert property (@(posedge CLK) disable iff (!rstN) wbDest == s3.dest)
		else reportMismatch("wbDest", $sampled(wbDest), $sampled(s3.dest));
	rsDataCheck: assert property (@(posedge CLK) disable iff (!rstN) rsData == expRs)
		else reportMismatch("rsData", $sampled(rsData), $sampled(expRs));
	rtDataCheck: assert property (@(posedge CLK) disable iff (!rstN) rtData == expRt)
		else reportMismatch("rtData", $sampled(rtData), $sampled(expRt));
	redirectCheck: assert property (@(posedge CLK) disable iff (!rstN) redirect == expRedirect)
		else reportMismatch("redirect", $sampled(redirect), $sampled(expRedirect));
	redirectPcCheck: assert property (@(posedge CLK) disable iff (!rstN)
		expRedirect |-> redirectPc == expPc)
		else reportMismatch("redirectPc", $sampled(redirectPc), $sampled(expPc));

	// r0 on either port
	zeroRegCheck: assert property (@(posedge CLK) disable iff (!rstN)
		(idInstr[25:21] != 5'd0 || rsData == '0) && (idInstr[20:16] != 5'd0 || rtData == '0))
		else reportFailure("register r0 read back a nonzero value");

	// Bubble stays empty in every stage, never writes back
	flushCheck: assert property (@(posedge CLK) disable iff (!rstN)
		(!s1.fl || exCtrl == '0) && (!s2.fl || memCtrl == '0) && (!s3.fl || wbCtrl == '0))
		else reportFailure("a flushed instruction carried a nonzero control bundle");

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles)
		begin
			$display("timeout: run did not finish within %0d cycles", maxCycles);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [31:0] rndA;
		logic [31:0] rndB;
		logic [31:0] rndC;
		rstN    = 1'b0;
		idInstr = '0;
		idPc    = '0;
		flush   = 1'b0;
		wbWrite = 1'b0;
		wbAddr  = '0;
		wbData  = '0;
		repeat (resetCycles) @(posedge CLK);
		rstN <= 1'b1;

		// Operands for the branch and jr cases
		issue(32'd0, 1'b0, 1'b1, 5'd8, 32'h0000_1234);
		issue(32'd0, 1'b0, 1'b1, 5'd9, 32'h0000_1234);
		issue(32'd0, 1'b0, 1'b1, 5'd10, 32'h0040_55a8);
		issue(encodeR(5'd11, 5'd11, 5'd3, fnAdd), 1'b0, 1'b1, 5'd11, 32'hdead_beef);	// Bypass
		issuePlain(encodeR(5'd11, 5'd10, 5'd4, fnSub));	// Now from storage
		issue(encodeR(5'd0, 5'd0, 5'd6, fnOr), 1'b0, 1'b1, 5'd0, 32'hffff_ffff);	// r0 write
		issuePlain(encodeR(5'd0, 5'd0, 5'd7, fnAnd));
		issuePlain(encodeI(opBeq, 5'd8, 5'd9, 16'h0003));	// Taken
		issuePlain({opJ, 26'h012_3456});	// Loses to the branch
		issuePlain(encodeI(opBne, 5'd8, 5'd9, 16'h0010));	// Not taken
		issuePlain(32'd0);
		issuePlain(encodeI(opBne, 5'd8, 5'd10, 16'hfffe));	// Taken, backward
		issuePlain(encodeI(opBeq, 5'd8, 5'd10, 16'h0004));	// Not taken
		issuePlain(encodeR(5'd10, 5'd0, 5'd0, fnJr));
		issuePlain({opJal, 26'h3ff_fff0});
		foreach (fnList[i])
			issuePlain(encodeR(5'd8, 5'd9, 5'd12, fnList[i]));
		issuePlain(encodeI(opAddi, 5'd8, 5'd13, 16'h8000));
		issuePlain(encodeI(opAndi, 5'd8, 5'd14, 16'h00ff));
		issuePlain(encodeI(opOri, 5'd9, 5'd15, 16'h0f0f));
		issuePlain(encodeI(opSlti, 5'd9, 5'd16, 16'hffff));
		issuePlain(encodeI(opLw, 5'd10, 5'd17, 16'h0010));
		issuePlain(encodeI(opSw, 5'd10, 5'd17, 16'h0014));
		issuePlain(encodeI(6'b111111, 5'd1, 5'd2, 16'h1111));	// Unlisted opcode
		// Flushed slots, including ones that would redirect
		issue(encodeI(opBeq, 5'd8, 5'd9, 16'h0003), 1'b1, 1'b0, 5'd0, 32'd0);
		issue({opJal, 26'h000_0040}, 1'b1, 1'b0, 5'd0, 32'd0);
		issue(encodeI(opLw, 5'd10, 5'd18, 16'h0000), 1'b1, 1'b0, 5'd0, 32'd0);
		issuePlain(encodeR(5'd1, 5'd2, 5'd3, fnAdd));

		repeat (randomCycles)
		begin
			lcgState = lcgNext(lcgState);
			rndA = lcgState;
			lcgState = lcgNext(lcgState);
			rndB = lcgState;
			lcgState = lcgNext(lcgState);
			rndC = lcgState;
			issue({pickOpcode(rndB[31:28]), rndA[25:6], pickFunct(rndB[27:22])},
				rndB[21:19] == 3'd0, rndB[18:17] == 2'd0, rndB[16:12], rndC);
		end

		repeat (4) issuePlain(32'd0);	// Drain the last slots through WB
		@(negedge CLK);
		$display("All tests passed");
		$finish;
	end

endmodule

// File: logic/aluControl.sv
// EX-stage decoder, combinational
// Unknown funct under aluOp 001 falls back to add
`timescale 1ns/1ns

module aluControl
	import mipsPkg::*;
(
	input  logic [2:0] aluOp,
	input  logic [1:0] hiLo,	// 10 mfhi, 01 mflo
	input  logic [5:0] funct,
	output aluFunc_t   aluFunc
);

	aluFunc_t rFunc;	// Function picked by funct alone

	always_comb
	begin
		case (funct)
			fnSub:   rFunc = aluSub;
			fnAnd:   rFunc = aluAnd;
			fnOr:    rFunc = aluOr;
			fnSlt:   rFunc = aluSlt;
			default: rFunc = aluAdd;	// fnAdd and anything unlisted
		endcase
	end

	always_comb
	begin
		case (aluOp)
			3'b000: aluFunc = aluAdd;	// addi, lw, sw
			3'b001:
			begin
				// HI/LO moves override the funct decode
				if (hiLo == 2'b10)
					aluFunc = aluMfhi;
				else if (hiLo == 2'b01)
					aluFunc = aluMflo;
				else
					aluFunc = rFunc;
			end
			3'b010: aluFunc = aluAnd;
			3'b011: aluFunc = aluOr;
			3'b100, 3'b101: aluFunc = aluSub;	// Branch compare
			3'b110: aluFunc = aluSlt;
			default: aluFunc = aluPass;	// 111, jumps
		endcase
	end

endmodule

// File: logic/decodePipe.sv
// Decode end of the pipe: ID decode, ID/EX, EX/MEM, MEM/WB
// No forwarding or stalls; flush and write-back data come from outside
`timescale 1ns/1ns

module decodePipe
	import mipsPkg::*;
(
	input  logic        CLK,
	input  logic        rstN,
	input  logic [31:0] idInstr,
	input  logic [31:0] idPc,
	input  logic        flush,
	input  logic        wbWrite,	// Write-back port
	input  logic [4:0]  wbAddr,
	input  logic [31:0] wbData,
	output logic [31:0] rsData,
	output logic [31:0] rtData,
	output exCtrl_t     exCtrl,
	output aluFunc_t    aluFunc,
	output memCtrl_t    memCtrl,
	output wbCtrl_t     wbCtrl,
	output logic [4:0]  exDest,
	output logic [4:0]  memDest,
	output logic [4:0]  wbDest,
	output logic        redirect,
	output logic [31:0] redirectPc
);

	regDst_t       regDst;
	jumpSel_t      jumpSel;
	exCtrl_t       idExCtrl;	// Decoder bundles, still in ID
	memCtrl_t      idMemCtrl;
	wbCtrl_t       idWbCtrl;
	logic [31:0]   pcPlus4;
	logic [31:0]   imm;
	logic [4:0]    dest;
	idExPayload_t  idExD;
	idExPayload_t  idExQ;
	exMemPayload_t exMemD;
	exMemPayload_t exMemQ;
	memWbPayload_t memWbD;
	memWbPayload_t memWbQ;

	mainControl mainCtl (
		.opcode  (idInstr[31:26]),
		.funct   (idInstr[5:0]),
		.flush   (flush),
		.regDst  (regDst),
		.jumpSel (jumpSel),
		.exCtrl  (idExCtrl),
		.memCtrl (idMemCtrl),
		.wbCtrl  (idWbCtrl)
	);

	regFile regs (
		.CLK    (CLK),
		.rstN   (rstN),
		.rsAddr (idInstr[25:21]),
		.rtAddr (idInstr[20:16]),
		.rsData (rsData),
		.rtData (rtData),
		.wrEn   (wbWrite),
		.wrAddr (wbAddr),
		.wrData (wbData)
	);

	assign pcPlus4 = idPc + 32'd4;
	assign imm     = {{16{idInstr[15]}}, idInstr[15:0]};

	always_comb
	begin
		case (regDst)
			dstRd:   dest = idInstr[15:11];
			dstRa:   dest = 5'd31;	// jal link
			default: dest = idInstr[20:16];
		endcase
	end

	assign idExD = '{ex: idExCtrl, mem: idMemCtrl, wb: idWbCtrl, rsData: rsData,
		rtData: rtData, imm: imm, dest: dest, funct: idInstr[5:0], pcPlus4: pcPlus4};

	// Clear here too, backs up the decoder's zero bundle
	stageReg #(.PayloadT(idExPayload_t)) idExReg (
		.CLK (CLK), .rstN (rstN), .clear (flush), .d (idExD), .q (idExQ)
	);

	assign exMemD = '{mem: idExQ.mem, wb: idExQ.wb, dest: idExQ.dest};

	stageReg #(.PayloadT(exMemPayload_t)) exMemReg (
		.CLK (CLK), .rstN (rstN), .clear (1'b0), .d (exMemD), .q (exMemQ)
	);

	assign memWbD = '{wb: exMemQ.wb, dest: exMemQ.dest};

	stageReg #(.PayloadT(memWbPayload_t)) memWbReg (
		.CLK (CLK), .rstN (rstN), .clear (1'b0), .d (memWbD), .q (memWbQ)
	);

	aluControl aluCtl (
		.aluOp   (idExQ.ex.aluOp),
		.hiLo    (idExQ.ex.hiLo),
		.funct   (idExQ.funct),
		.aluFunc (aluFunc)
	);

	nextPcUnit nextPc (
		.jumpSel    (jumpSel),
		.idPcPlus4  (pcPlus4),
		.index      (idInstr[25:0]),
		.rsData     (rsData),
		.exAluOp    (idExQ.ex.aluOp),
		.exRsData   (idExQ.rsData),
		.exRtData   (idExQ.rtData),
		.exImm      (idExQ.imm),
		.exPcPlus4  (idExQ.pcPlus4),
		.redirect   (redirect),
		.redirectPc (redirectPc)
	);

	assign exCtrl  = idExQ.ex;
	assign exDest  = idExQ.dest;
	assign memCtrl = exMemQ.mem;
	assign memDest = exMemQ.dest;
	assign wbCtrl  = memWbQ.wb;
	assign wbDest  = memWbQ.dest;

	// Flushed slot reaches WB three edges later with no register write
	flushNoWrite: assert property (@(posedge CLK) disable iff (!rstN)
		flush |-> ##3 !wbCtrl.regWrite)
		else $error("decodePipe: flushed slot wrote a register");

endmodule

// File: logic/mainControl.sv
// Purely combinational, no state; unlisted opcodes decode as R-type
// Flush forces a bubble for every opcode, not only R-type
`timescale 1ns/1ns

module mainControl
	import mipsPkg::*;
(
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	input  logic       flush,	// From hazard unit
	output regDst_t    regDst,
	output jumpSel_t   jumpSel,
	output exCtrl_t    exCtrl,
	output memCtrl_t   memCtrl,
	output wbCtrl_t    wbCtrl
);

	always_comb
	begin
		// R-type is the starting point
		regDst  = dstRd;
		jumpSel = jmpNone;
		exCtrl  = '{aluOp: 3'b001, aluSrc: 1'b0, hiLo: 2'b00};
		memCtrl = '{memRead: 1'b0, memWrite: 1'b0};
		wbCtrl  = '{memToReg: 2'b00, regWrite: 1'b1};

		case (opcode)
			opR:
			begin
				case (funct)
					fnJr:   jumpSel = jmpReg;
					fnMult: wbCtrl.regWrite = 1'b0;	// Result lands in HI/LO
					fnDiv:  wbCtrl.regWrite = 1'b0;
					fnMfhi: exCtrl.hiLo = 2'b10;
					fnMflo: exCtrl.hiLo = 2'b01;
					default: ;	// Plain ALU op, funct decoded in EX
				endcase
			end
			opJ:
			begin
				jumpSel         = jmpImm;
				exCtrl.aluOp    = 3'b111;
				wbCtrl.regWrite = 1'b0;
			end
			opJal:
			begin
				regDst          = dstRa;	// Link into r31
				jumpSel         = jmpImm;
				exCtrl.aluOp    = 3'b111;
				wbCtrl.memToReg = 2'b10;
			end
			opAddi, opAndi, opOri, opSlti:
			begin
				regDst        = dstRt;
				exCtrl.aluSrc = 1'b1;
				case (opcode)	// Only the ALU op differs
					opAndi:  exCtrl.aluOp = 3'b010;
					opOri:   exCtrl.aluOp = 3'b011;
					opSlti:  exCtrl.aluOp = 3'b110;
					default: exCtrl.aluOp = 3'b000;
				endcase
			end
			opBeq:
			begin
				exCtrl.aluOp    = 3'b100;	// Compare equal in EX
				wbCtrl.regWrite = 1'b0;
			end
			opBne:
			begin
				exCtrl.aluOp    = 3'b101;
				wbCtrl.regWrite = 1'b0;
			end
			opLw:
			begin
				regDst          = dstRt;
				exCtrl.aluOp    = 3'b000;	// Address add
				exCtrl.aluSrc   = 1'b1;
				memCtrl.memRead = 1'b1;
				wbCtrl.memToReg = 2'b01;
			end
			opSw:
			begin
				exCtrl.aluOp     = 3'b000;
				exCtrl.aluSrc    = 1'b1;
				memCtrl.memWrite = 1'b1;
				wbCtrl.regWrite  = 1'b0;
			end
			default: ;	// Unknown opcode stays R-type
		endcase

		// Bubble wins over everything above
		if (flush)
		begin
			regDst  = dstRt;
			jumpSel = jmpNone;
			exCtrl  = '0;
			memCtrl = '0;
			wbCtrl  = '0;
		end
	end

endmodule

// File: logic/mipsPkg.sv
// Shared codes and bundle types for the decode end of the pipeline
// Field order of the control bundles matches the legacy bit layout (WB 3, MEM 2, EX 6)
package mipsPkg;

	// Primary opcodes, instr[31:26]
	localparam logic [5:0] opR    = 6'b000000;
	localparam logic [5:0] opJ    = 6'b000010;
	localparam logic [5:0] opJal  = 6'b000011;
	localparam logic [5:0] opBeq  = 6'b000100;
	localparam logic [5:0] opBne  = 6'b000101;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri  = 6'b001101;
	localparam logic [5:0] opLw   = 6'b100011;
	localparam logic [5:0] opSw   = 6'b101011;

	// R-type funct codes, instr[5:0]
	localparam logic [5:0] fnJr   = 6'b001000;
	localparam logic [5:0] fnMfhi = 6'b010000;
	localparam logic [5:0] fnMflo = 6'b010010;
	localparam logic [5:0] fnMult = 6'b011000;
	localparam logic [5:0] fnDiv  = 6'b011010;
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSlt  = 6'b101010;

	typedef struct packed {
		logic [1:0] memToReg;	// 00 ALU, 01 memory, 10 link
		logic       regWrite;
	} wbCtrl_t;

	typedef struct packed {
		logic memRead;
		logic memWrite;
	} memCtrl_t;

	typedef struct packed {
		logic [2:0] aluOp;
		logic       aluSrc;	// 1 picks the immediate
		logic [1:0] hiLo;	// 10 HI, 01 LO
	} exCtrl_t;

	typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b10} regDst_t;

	typedef enum logic [1:0] {jmpNone = 2'b00, jmpImm = 2'b01, jmpReg = 2'b10} jumpSel_t;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluPass, aluMfhi, aluMflo
	} aluFunc_t;

	// ID/EX carries operands plus everything the branch check needs
	typedef struct packed {
		exCtrl_t     ex;
		memCtrl_t    mem;
		wbCtrl_t     wb;
		logic [31:0] rsData;
		logic [31:0] rtData;
		logic [31:0] imm;	// Already sign extended
		logic [4:0]  dest;
		logic [5:0]  funct;
		logic [31:0] pcPlus4;
	} idExPayload_t;

	typedef struct packed {
		memCtrl_t   mem;
		wbCtrl_t    wb;
		logic [4:0] dest;
	} exMemPayload_t;

	typedef struct packed {
		wbCtrl_t    wb;
		logic [4:0] dest;
	} memWbPayload_t;

endpackage

// File: logic/nextPcUnit.sv
// Jumps resolve in ID, branches in EX; a taken branch beats a jump
// redirect is combinational, so it lasts as long as the slot sits in the stage
`timescale 1ns/1ns

module nextPcUnit
	import mipsPkg::*;
(
	input  jumpSel_t    jumpSel,
	input  logic [31:0] idPcPlus4,
	input  logic [25:0] index,	// instr[25:0]
	input  logic [31:0] rsData,	// jr target
	input  logic [2:0]  exAluOp,
	input  logic [31:0] exRsData,
	input  logic [31:0] exRtData,
	input  logic [31:0] exImm,
	input  logic [31:0] exPcPlus4,
	output logic        redirect,
	output logic [31:0] redirectPc
);

	logic [31:0] jumpTarget;
	logic [31:0] branchTarget;
	logic        operandsEqual;
	logic        branchTaken;
	logic        jumpTaken;

	// Region bits from PC+4, word index below
	assign jumpTarget = (jumpSel == jmpReg) ? rsData : {idPcPlus4[31:28], index, 2'b00};

	assign branchTarget  = exPcPlus4 + {exImm[29:0], 2'b00};
	assign operandsEqual = (exRsData == exRtData);

	// beq 100, bne 101
	assign branchTaken = ((exAluOp == 3'b100) && operandsEqual)
		|| ((exAluOp == 3'b101) && !operandsEqual);
	assign jumpTaken = (jumpSel != jmpNone);

	always_comb
	begin
		redirect   = branchTaken || jumpTaken;
		redirectPc = '0;	// Don't care when no redirect
		if (branchTaken)
			redirectPc = branchTarget;	// Older instruction first
		else if (jumpTaken)
			redirectPc = jumpTarget;
	end

	// Known controls and operands must give a known redirect
	redirectKnown: assert final ($isunknown({jumpSel, exAluOp}) || !$isunknown(redirect))
		else $error("nextPcUnit: redirect unknown with known controls");

endmodule

// File: logic/regFile.sv
// 32x32 registers, r0 reads zero, storage cleared by reset
// Same-cycle write is bypassed to both read ports
`timescale 1ns/1ns

module regFile
(
	input  logic        CLK,
	input  logic        rstN,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	output logic [31:0] rsData,
	output logic [31:0] rtData,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData
);

	logic [31:0] regs [32];
	logic        wrLive;	// Write that actually lands
	logic        rsHit;
	logic        rtHit;

	assign wrLive = wrEn && (wrAddr != 5'd0);	// r0 never written

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrLive)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Bypass only for a write that lands, so r0 stays zero
	assign rsHit = wrLive && (wrAddr == rsAddr);
	assign rtHit = wrLive && (wrAddr == rtAddr);

	assign rsData = rsHit ? wrData : regs[rsAddr];
	assign rtData = rtHit ? wrData : regs[rtAddr];

	// r0 zero on both ports, bypass and reset path together
	zeroReg: assert property (@(posedge CLK) disable iff (!rstN)
		(rsAddr == 5'd0 |-> rsData == '0) and (rtAddr == 5'd0 |-> rtData == '0))
		else $error("regFile: r0 read back nonzero");

endmodule

// File: logic/stageReg.sv
// Generic pipeline register, advances every cycle, no stall
// Reset and clear both load an all-zero payload
`timescale 1ns/1ns

module stageReg
#(
	parameter type PayloadT = logic [31:0]
)
(
	input  logic    CLK,
	input  logic    rstN,
	input  logic    clear,	// Synchronous bubble insert
	input  PayloadT d,
	output PayloadT q
);

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			q <= '0;
		else if (clear)
			q <= '0;
		else
			q <= d;
	end

endmodule

// File: vlog.f
logic/mipsPkg.sv
logic/mainControl.sv
logic/aluControl.sv
logic/regFile.sv
logic/nextPcUnit.sv
logic/stageReg.sv
logic/decodePipe.sv
bench/decodePipeTb.sv
